// File: source/ucpd_line_pkg.sv
package ucpd_line_pkg;

  // --------------------------------------------------
  // CC line configuration
  // --------------------------------------------------

  // glitch filter on the synchronized CC input
  // number of equal samples before a new high level is taken
  typedef enum logic [1:0] {
    FILT_BYPASS = 2'd0,
    FILT_TWO    = 2'd1,
    FILT_THREE  = 2'd2
  } filt_mode_e;

  // static line setup, 3 bits
  typedef struct packed {
    logic       ucpden;  // peripheral enable, gates rx input and tx output
    filt_mode_e filt;
  } line_cfg_t;

  // --------------------------------------------------
  // transmit control
  // --------------------------------------------------

  // strobes come from an external bit clock divider
  typedef struct packed {
    logic tx_en;     // encoder active, output held low otherwise
    logic tx_bit;    // bit being sent
    logic bit_stb;   // bit boundary
    logic half_stb;  // every half bit
  } tx_ctl_t;

endpackage

// File: source/ucpd_rx_pkg.sv
package ucpd_rx_pkg;

  // --------------------------------------------------
  // receive path types
  // --------------------------------------------------

  // ucpd_clk cycles between two CC edges
  // also used for the half/full UI threshold
  localparam int UI_CNT_W = 11;

  typedef logic [UI_CNT_W-1:0] ui_cnt_t;

  // preamble training
  // idle until the frame opens, then three intervals, then locked
  typedef enum logic [1:0] {
    TR_IDLE    = 2'd0,
    TR_CAPTURE = 2'd1,
    TR_LOCKED  = 2'd2
  } train_state_e;

  // one decoded BMC bit
  typedef struct packed {
    logic vld;    // single cycle strobe
    logic value;  // decoded bit
  } rx_bit_t;

endpackage

// File: source/ucpd_cc_line.sv
`timescale 1ns/1ps

module ucpd_cc_line (
  input  logic                     ucpd_clk,
  input  logic                     ic_rst_n,
  input  logic                     cc_in,
  input  ucpd_line_pkg::line_cfg_t cfg,
  input  ucpd_line_pkg::tx_ctl_t   tx,
  output logic                     cc_lvl,
  output logic                     cc_edge,
  output logic                     cc_out
);

  logic       cc_gated;
  logic [1:0] sync_ff;
  logic       cc_sync;
  logic [1:0] cc_hist;
  logic       lvl_nxt;
  logic       tx_toggle;
  logic       tx_bmc;

  // --------------------------------------------------
  // receive: synchronizer and glitch filter
  // --------------------------------------------------

  // input only seen while the peripheral is enabled
  assign cc_gated = cc_in & cfg.ucpden;
  assign cc_sync  = sync_ff[1];

  // two flop synchronizer, history follows behind it
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sync_ff <= 2'b11;
      cc_hist <= 2'b11;
    end else begin
      sync_ff <= {sync_ff[0], cc_gated};
      cc_hist <= {cc_hist[0], cc_sync};
    end
  end

  // high only after enough consecutive high samples
  // a low sample drops the level at once
  always_comb begin
    case (cfg.filt)
      ucpd_line_pkg::FILT_TWO:   lvl_nxt = cc_sync & cc_hist[0];
      ucpd_line_pkg::FILT_THREE: lvl_nxt = cc_sync & cc_hist[0] & cc_hist[1];
      default:                   lvl_nxt = cc_sync;
    endcase
  end

  // filtered level and its change strobe, registered together
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      cc_lvl  <= 1'b1;
      cc_edge <= 1'b0;
    end else begin
      cc_lvl  <= lvl_nxt;
      cc_edge <= lvl_nxt ^ cc_lvl;
    end
  end

  // --------------------------------------------------
  // transmit: BMC encoder
  // --------------------------------------------------

  // one: toggle every half bit
  // zero: toggle on the bit boundary only
  assign tx_toggle = tx.tx_bit ? tx.half_stb : tx.bit_stb;

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      tx_bmc <= 1'b0;
    end else if (!tx.tx_en) begin
      tx_bmc <= 1'b0;
    end else if (tx_toggle) begin
      tx_bmc <= ~tx_bmc;
    end
  end

  // pin stays low while the peripheral is off
  assign cc_out = tx_bmc & cfg.ucpden;

endmodule

// File: source/ucpd_ui_trainer.sv
`timescale 1ns/1ps

module ucpd_ui_trainer #(
  parameter int PRE_EDGES = 96
) (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 cc_lvl,
  input  logic                 cc_edge,
  input  logic                 rx_stop,
  output ucpd_rx_pkg::ui_cnt_t ui_th,
  output logic                 rx_locked,
  output logic                 pre_done
);

  localparam int EDGE_W = $clog2(PRE_EDGES + 1);

  ucpd_rx_pkg::train_state_e state;
  ucpd_rx_pkg::ui_cnt_t      hi_cnt;
  ucpd_rx_pkg::ui_cnt_t      lo_cnt;
  ucpd_rx_pkg::ui_cnt_t      run_len;
  ucpd_rx_pkg::ui_cnt_t      ui_a;
  ucpd_rx_pkg::ui_cnt_t      ui_b;
  logic [1:0]                cap_idx;
  logic [12:0]               ui_sum;
  logic [14:0]               sum_x3;
  logic [11:0]               th_calc;
  logic                      b_longest;
  logic                      frame_edge;
  logic [EDGE_W-1:0]         edge_cnt;

  // --------------------------------------------------
  // high and low run lengths
  // --------------------------------------------------

  // both saturate, idle gaps can be long
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      hi_cnt <= '0;
      lo_cnt <= '0;
    end else if (cc_lvl) begin
      lo_cnt <= '0;
      if (hi_cnt != '1) hi_cnt <= hi_cnt + 1'b1;
    end else begin
      hi_cnt <= '0;
      if (lo_cnt != '1) lo_cnt <= lo_cnt + 1'b1;
    end
  end

  // on an edge cc_lvl is already the new level
  assign run_len = cc_lvl ? lo_cnt : hi_cnt;

  // threshold = (a+b+c)*3/8, between half and full UI
  assign ui_sum    = 13'(ui_a) + 13'(ui_b) + 13'(run_len);
  assign sum_x3    = 15'(ui_sum) * 15'd3;
  assign th_calc   = sum_x3[14:3];
  // middle interval longest: leading one was lost
  assign b_longest = (ui_b > ui_a) && (ui_b > run_len);

  // --------------------------------------------------
  // training FSM
  // --------------------------------------------------

  // idle line is low, the preamble opens with a rising edge
  // cap_idx 3 skips one interval to shift the phase after a reject
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      state   <= ucpd_rx_pkg::TR_IDLE;
      cap_idx <= 2'd0;
      ui_th   <= '0;
    end else if (rx_stop) begin
      state   <= ucpd_rx_pkg::TR_IDLE;
      cap_idx <= 2'd0;
      ui_th   <= '0;
    end else if (cc_edge) begin
      case (state)
        ucpd_rx_pkg::TR_IDLE: begin
          if (cc_lvl) begin
            state   <= ucpd_rx_pkg::TR_CAPTURE;
            cap_idx <= 2'd0;
          end
        end
        ucpd_rx_pkg::TR_CAPTURE: begin
          case (cap_idx)
            2'd0: cap_idx <= 2'd1;
            2'd1: cap_idx <= 2'd2;
            2'd2: begin
              if (b_longest) begin
                cap_idx <= 2'd3;
              end else begin
                ui_th   <= th_calc[11] ? '1 : th_calc[10:0];
                state   <= ucpd_rx_pkg::TR_LOCKED;
                cap_idx <= 2'd0;
              end
            end
            default: cap_idx <= 2'd0;
          endcase
        end
        default: ;
      endcase
    end
  end

  // interval a and b, c is taken straight from run_len
  always_ff @(posedge ucpd_clk) begin
    if (cc_edge && state == ucpd_rx_pkg::TR_CAPTURE) begin
      if (cap_idx == 2'd0) ui_a <= run_len;
      if (cap_idx == 2'd1) ui_b <= run_len;
    end
  end

  assign rx_locked = (state == ucpd_rx_pkg::TR_LOCKED);

  // --------------------------------------------------
  // preamble edge count
  // --------------------------------------------------

  // opening edge counts as the first one
  assign frame_edge = cc_edge && ((state != ucpd_rx_pkg::TR_IDLE) || cc_lvl);

  // stops at PRE_EDGES so the pulse comes once per frame
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      edge_cnt <= '0;
      pre_done <= 1'b0;
    end else begin
      pre_done <= 1'b0;
      if (rx_stop) begin
        edge_cnt <= '0;
      end else if (frame_edge && edge_cnt != EDGE_W'(PRE_EDGES)) begin
        edge_cnt <= edge_cnt + 1'b1;
        pre_done <= (edge_cnt == EDGE_W'(PRE_EDGES - 1));
      end
    end
  end

endmodule

// File: source/ucpd_bmc_decoder.sv
`timescale 1ns/1ps

module ucpd_bmc_decoder (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 cc_edge,
  input  ucpd_rx_pkg::ui_cnt_t ui_th,
  input  logic                 rx_locked,
  input  logic                 rx_stop,
  output ucpd_rx_pkg::rx_bit_t rx_bit
);

  ucpd_rx_pkg::ui_cnt_t iv_cnt;
  logic                 run_en;
  logic                 long_iv;
  logic                 pend_short;

  // --------------------------------------------------
  // interval timing
  // --------------------------------------------------

  assign run_en  = rx_locked && !rx_stop;

  // longer than the threshold means a full UI
  assign long_iv = (iv_cnt > ui_th);

  // cycles since the last edge
  // pend_short set after the first half of a one
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      iv_cnt     <= '0;
      pend_short <= 1'b0;
    end else if (!run_en) begin
      iv_cnt     <= '0;
      pend_short <= 1'b0;
    end else if (cc_edge) begin
      iv_cnt <= ucpd_rx_pkg::ui_cnt_t'(1);
      // long drops a stray half bit, short alternates
      if (long_iv) begin
        pend_short <= 1'b0;
      end else begin
        pend_short <= ~pend_short;
      end
    end else if (iv_cnt != '1) begin
      iv_cnt <= iv_cnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // bit decision
  // --------------------------------------------------

  // long interval ends a zero
  // second short in a row ends a one
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      rx_bit <= '0;
    end else begin
      rx_bit.vld <= run_en && cc_edge && (long_iv || pend_short);
      if (run_en && cc_edge) begin
        rx_bit.value <= ~long_iv;
      end
    end
  end

endmodule

// File: source/ucpd_bmc_phy.sv
`timescale 1ns/1ps

module ucpd_bmc_phy #(
  parameter int PRE_EDGES = 96
) (
  input  logic                     ucpd_clk,
  input  logic                     ic_rst_n,
  input  logic                     cc_in,
  input  ucpd_line_pkg::line_cfg_t cfg,
  input  ucpd_line_pkg::tx_ctl_t   tx,
  input  logic                     rx_stop,
  output logic                     cc_out,
  output ucpd_rx_pkg::rx_bit_t     rx_bit,
  output logic                     rx_locked,
  output logic                     pre_done
);

  // --------------------------------------------------
  // line to trainer and decoder
  // --------------------------------------------------

  logic                 cc_lvl;
  logic                 cc_edge;
  ucpd_rx_pkg::ui_cnt_t ui_th;

  // sync, filter and BMC encode
  ucpd_cc_line u_cc_line (
    .ucpd_clk (ucpd_clk),
    .ic_rst_n (ic_rst_n),
    .cc_in    (cc_in),
    .cfg      (cfg),
    .tx       (tx),
    .cc_lvl   (cc_lvl),
    .cc_edge  (cc_edge),
    .cc_out   (cc_out)
  );

  // preamble training, threshold and lock
  ucpd_ui_trainer #(
    .PRE_EDGES (PRE_EDGES)
  ) u_ui_trainer (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_lvl    (cc_lvl),
    .cc_edge   (cc_edge),
    .rx_stop   (rx_stop),
    .ui_th     (ui_th),
    .rx_locked (rx_locked),
    .pre_done  (pre_done)
  );

  // bits out once locked
  ucpd_bmc_decoder u_bmc_decoder (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_edge   (cc_edge),
    .ui_th     (ui_th),
    .rx_locked (rx_locked),
    .rx_stop   (rx_stop),
    .rx_bit    (rx_bit)
  );

endmodule

// File: tests/ucpd_clk_gen.sv
`timescale 1ns/1ps

module ucpd_clk_gen #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// File: tests/ucpd_bmc_assert.sv
`timescale 1ns/1ps

module ucpd_bmc_assert (
  input logic                     ucpd_clk,
  input logic                     ic_rst_n,
  input ucpd_line_pkg::line_cfg_t cfg,
  input logic                     cc_out,
  input ucpd_rx_pkg::rx_bit_t     rx_bit,
  input logic                     rx_locked,
  input logic                     pre_done
);

  // --------------------------------------------------
  // top level protocol rules
  // --------------------------------------------------

  // decoded bits only while locked
  vld_needs_lock: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_bit.vld |-> rx_locked)
    else $error("rx_bit.vld high while rx_locked is low");

  // preamble pulse is a single cycle
  pre_done_single: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    pre_done |=> !pre_done)
    else $error("pre_done held for more than one cycle");

  // pin quiet with the peripheral off
  out_off_when_disabled: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    !cfg.ucpden |-> !cc_out)
    else $error("cc_out high while ucpden is low");

endmodule

bind ucpd_bmc_phy ucpd_bmc_assert u_bmc_assert (.*);

// File: tests/ucpd_tb.sv
`timescale 1ns/1ps

module ucpd_tb;

  localparam int PRE_BITS = 16;
  localparam int TX_HALF  = 4;

  logic                     ucpd_clk;
  logic                     ic_rst_n;
  logic                     cc_in;
  logic                     rx_stop;
  ucpd_line_pkg::line_cfg_t cfg;
  ucpd_line_pkg::tx_ctl_t   tx;
  logic                     cc_out;
  logic                     rx_locked;
  logic                     pre_done;
  ucpd_rx_pkg::rx_bit_t     rx_bit;

  // test table from the stimulus file
  string       t_name[$];
  int          t_mode[$];
  int          t_half[$];
  int          t_glitch[$];
  int          t_len[$];
  logic [31:0] t_data[$];
  int          t_ones[$];

  integer seed = 58226;
  int     wd_cycles = 0;
  int     n_pass = 0;
  int     n_fail = 0;
  int     test_err;
  int     pre_cnt;
  int     stray;
  logic   frame_on;
  logic   glitch_arm;
  logic   lvl_now;
  bit     got_bits[$];

  ucpd_clk_gen u_clk_gen (.clk(ucpd_clk));

  ucpd_bmc_phy #(.PRE_EDGES(24)) UUT (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_in     (cc_in),
    .cfg       (cfg),
    .tx        (tx),
    .rx_stop   (rx_stop),
    .cc_out    (cc_out),
    .rx_bit    (rx_bit),
    .rx_locked (rx_locked),
    .pre_done  (pre_done)
  );

  // --------------------------------------------------
  // cycle step and output sampling
  // --------------------------------------------------

  // outputs settled 1 ns after the edge, inputs change right after
  task automatic tick();
    @(posedge ucpd_clk);
    #1;
    if (rx_bit.vld) begin
      if (frame_on) got_bits.push_back(rx_bit.value);
      else stray++;
    end
    if (pre_done) pre_cnt++;
  endtask

  task automatic value_error(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s %s expected 0x%0h actual 0x%0h", name, what, exp, act);
    test_err++;
  endtask

  // one level for n cycles, optional single cycle pulse in a low level
  task automatic drive_level(input logic lvl, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      cc_in = lvl;
      if (glitch_arm && !lvl && i == n / 2) cc_in = 1'b1;
      tick();
    end
    if (glitch_arm && !lvl) glitch_arm = 1'b0;
  endtask

  // BMC: toggle at every bit start, extra toggle mid bit for a one
  task automatic send_bit(input logic b, input int h);
    lvl_now = ~lvl_now;
    if (b) begin
      drive_level(lvl_now, h);
      lvl_now = ~lvl_now;
      drive_level(lvl_now, h);
    end else begin
      drive_level(lvl_now, 2 * h);
    end
  endtask

  // --------------------------------------------------
  // stimulus file
  // --------------------------------------------------

  task automatic load_tests();
    int          fd;
    int          rc;
    string       txt;
    string       nm;
    int          m;
    int          h;
    int          g;
    int          l;
    int          o;
    logic [31:0] d;
    fd = $fopen("tests/ucpd_stimulus.txt", "r");
    if (fd == 0) begin
      $display("stimulus file tests/ucpd_stimulus.txt could not be opened");
      n_fail++;
      return;
    end
    while (!$feof(fd)) begin
      rc = $fgets(txt, fd);
      if (rc == 0 || txt.len() < 2 || txt.substr(0, 0) == "#") continue;
      rc = $sscanf(txt, "%s %d %d %d %d %h %d", nm, m, h, g, l, d, o);
      if (rc != 7) continue;
      t_name.push_back(nm);
      t_mode.push_back(m);
      t_half.push_back(h);
      t_glitch.push_back(g);
      t_len.push_back(l);
      t_data.push_back(d);
      t_ones.push_back(o);
      // frame plus stop and the longest idle gap
      wd_cycles += (PRE_BITS + l + 2) * 2 * h + 80;
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // receive frame test
  // --------------------------------------------------

  task automatic run_frame(input int k);
    int          i;
    int          h;
    int          gap;
    int          ones;
    logic [31:0] exp;
    logic [31:0] act;
    h        = t_half[k];
    test_err = 0;
    pre_cnt  = 0;
    stray    = 0;
    got_bits.delete();
    cfg.filt = ucpd_line_pkg::filt_mode_e'(2'(t_mode[k]));
    frame_on = 1'b1;
    lvl_now  = 1'b0;
    // preamble 0101..., 24 edges
    for (i = 0; i < PRE_BITS; i++) send_bit(i[0], h);
    if (!rx_locked) begin
      $display("test %s: rx_locked still low at the first payload bit", t_name[k]);
      test_err++;
    end
    glitch_arm = (t_glitch[k] != 0);
    for (i = 0; i < t_len[k]; i++) send_bit(t_data[k][i], h);
    // closing edge times the last payload bit
    lvl_now = ~lvl_now;
    drive_level(lvl_now, 2 * h);
    rx_stop = 1'b1;
    tick();
    rx_stop = 1'b0;
    tick();
    if (rx_locked) begin
      $display("test %s: rx_locked still high 2 cycles after rx_stop", t_name[k]);
      test_err++;
    end
    frame_on = 1'b0;
    cc_in    = 1'b0;
    // idle gap, any strobe here counts as stray
    gap = 20 + int'($unsigned($random(seed)) % 40);
    repeat (gap) tick();
    exp  = '0;
    act  = '0;
    ones = 0;
    for (i = 0; i < t_len[k]; i++) exp[i] = t_data[k][i];
    if (got_bits.size() < t_len[k]) begin
      $display("test %s: only %0d bits decoded, payload has %0d", t_name[k],
               got_bits.size(), t_len[k]);
      test_err++;
    end else begin
      for (i = 0; i < t_len[k]; i++) begin
        act[i] = got_bits[got_bits.size() - t_len[k] + i];
        if (act[i]) ones++;
      end
      if (act !== exp) value_error(t_name[k], "payload", exp, act);
      if (ones != t_ones[k]) value_error(t_name[k], "ones", t_ones[k], ones);
    end
    if (pre_cnt != 1) value_error(t_name[k], "pre_done pulses", 1, pre_cnt);
    if (stray != 0) value_error(t_name[k], "strobes between frames", 0, stray);
  endtask

  // --------------------------------------------------
  // transmit encoder test
  // --------------------------------------------------

  // regular strobes, counts cc_out transitions and high samples
  task automatic drive_tx_bits(input logic [15:0] bits, output int toggles,
                               output int highs);
    int   i;
    int   j;
    logic prev;
    toggles = 0;
    highs   = 0;
    prev    = cc_out;
    for (i = 0; i < 16; i++) begin
      tx.tx_bit = bits[i];
      for (j = 0; j < 2 * TX_HALF; j++) begin
        tx.bit_stb  = (j == 0);
        tx.half_stb = (j == 0) || (j == TX_HALF);
        tick();
        if (cc_out !== prev) toggles++;
        if (cc_out !== 1'b0) highs++;
        prev = cc_out;
      end
    end
    tx.bit_stb  = 1'b0;
    tx.half_stb = 1'b0;
  endtask

  task automatic run_encoder();
    int          i;
    int          tog;
    int          hi;
    int          exp_tog;
    logic [15:0] bits;
    test_err = 0;
    bits     = 16'($random(seed));
    exp_tog  = 0;
    for (i = 0; i < 16; i++) exp_tog += bits[i] ? 2 : 1;
    cfg.ucpden = 1'b1;
    tx.tx_en   = 1'b1;
    drive_tx_bits(bits, tog, hi);
    if (tog != exp_tog) value_error("encoder", "transitions", exp_tog, tog);
    tx.tx_en = 1'b0;
    tick();
    // peripheral off, encoder running
    cfg.ucpden = 1'b0;
    tx.tx_en   = 1'b1;
    drive_tx_bits(bits, tog, hi);
    if (hi != 0) value_error("encoder", "high cycles with ucpden low", 0, hi);
    tx.tx_en = 1'b0;
    tick();
    // peripheral on, encoder off
    cfg.ucpden = 1'b1;
    drive_tx_bits(bits, tog, hi);
    if (hi != 0) value_error("encoder", "high cycles with tx_en low", 0, hi);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    int k;
    ic_rst_n   = 1'b0;
    cc_in      = 1'b0;
    rx_stop    = 1'b0;
    cfg.ucpden = 1'b1;
    cfg.filt   = ucpd_line_pkg::FILT_BYPASS;
    tx         = '0;
    frame_on   = 1'b0;
    glitch_arm = 1'b0;
    lvl_now    = 1'b0;
    stray      = 0;
    pre_cnt    = 0;
    load_tests();
    wd_cycles += 3 * 16 * 2 * TX_HALF + 1000;
    repeat (8) @(posedge ucpd_clk);
    #1;
    ic_rst_n = 1'b1;
    repeat (10) tick();
    for (k = 0; k < t_name.size(); k++) begin
      run_frame(k);
      if (test_err == 0) n_pass++;
      else n_fail++;
      $display("test %s finished with %0d errors", t_name[k], test_err);
    end
    run_encoder();
    if (test_err == 0) n_pass++;
    else n_fail++;
    $display("test encoder finished with %0d errors", test_err);
    $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog sized from the frame lengths
  initial begin
    wait (wd_cycles > 1000);
    repeat (wd_cycles) @(posedge ucpd_clk);
    $display("watchdog: run did not end within %0d cycles", wd_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: tests/ucpd_stimulus.txt
# name mode(0 bypass 1 two 2 three) half_ui glitch bits payload_hex ones
# payload is sent lsb first, ones is the count of ones in the payload
bypass_h8     0  8 0 16 A5C3     8
bypass_h12    0 12 0 32 DEADBEEF 24
bypass_odd    0 11 0  8 96       4
two_h8        1  8 0 20 F0F0F    12
two_h16       1 16 0 24 123456   9
three_h10     2 10 0 16 FFFF     16
three_h20     2 20 0 32 00000000 0
three_h8      2  8 0 12 ABC      7
two_glitch    1  9 1 16 0000     0
three_glitch  2 14 1 24 8001A5   6
two_glitch_b  1 12 1 32 0F0F00FF 16

// File: flist.f
source/ucpd_line_pkg.sv
source/ucpd_rx_pkg.sv
source/ucpd_cc_line.sv
source/ucpd_ui_trainer.sv
source/ucpd_bmc_decoder.sv
source/ucpd_bmc_phy.sv
tests/ucpd_clk_gen.sv
tests/ucpd_bmc_assert.sv
tests/ucpd_tb.sv

// File: Makefile
# Verilator build and run of the BMC phy testbench
TOP := ucpd_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "result: fail"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "result: run incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
